//--- compile.f
+incdir+.
ahb_pkg.sv
spm_pkg.sv
spm_ram.sv
spm_arbiter.sv
ahb_slave_adapter.sv
ahb_spm_top.sv
tb_ahb_spm.sv

//--- tb_ahb_spm.sv
/*
 * Table-driven testbench for the AHB-Lite scratchpad bridge
 * AHB tests use addresses below 0x100, core load stays in 0x800 and up
 * Latency is checked only for rows without core load
 */
`timescale 1ns/1ps

module tb_ahb_spm
  import ahb_pkg::*;
  import spm_pkg::*;
;

  localparam int PERIOD    = 100;
  localparam int RESET_CYC = 4;
  localparam int MAX_ROWS  = 40;

  logic      clk_i;
  logic      rst_ni;
  ahb_req_t  ahb_req;
  spm_req_t  core_req;
  ahb_resp_t ahb_resp;
  spm_resp_t core_resp;

  // Stimulus table
  string      row_name  [MAX_ROWS];
  ahb_trans_e row_trans [MAX_ROWS];
  ahb_burst_e row_burst [MAX_ROWS];
  ahb_size_t  row_size  [MAX_ROWS];
  logic       row_write [MAX_ROWS];
  addr_t      row_addr  [MAX_ROWS];
  int         row_load  [MAX_ROWS];
  int         n_rows;

  logic [7:0]  model [4096];
  logic [31:0] lfsr_q;
  int          errors;
  int          cycles;
  int          limit;

  // Core port state
  logic        core_acked;
  int          core_wait;
  logic        core_rd_pend;
  addr_t       core_rd_addr;

  ahb_spm_top dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ahb_req_i   (ahb_req),
    .core_req_i  (core_req),
    .ahb_resp_o  (ahb_resp),
    .core_resp_o (core_resp)
  );

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD/2) clk_i = ~clk_i;
  end

  // Run limit from the total row length
  initial begin
    cycles = 0;
    while (limit == 0 || cycles <= limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the bus stopped making progress", cycles);
    $display("TEST FAIL");
    $finish;
  end

  task automatic add_row(input string name, input ahb_trans_e tr, input ahb_burst_e bu,
                         input ahb_size_t sz, input logic wr, input addr_t ad, input int ld);
    row_name[n_rows]  = name;
    row_trans[n_rows] = tr;
    row_burst[n_rows] = bu;
    row_size[n_rows]  = sz;
    row_write[n_rows] = wr;
    row_addr[n_rows]  = ad;
    row_load[n_rows]  = ld;
    n_rows++;
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  function automatic logic [31:0] model_word(input addr_t a);
    int w;
    w = int'(a[11:0]) & ~3;
    return {model[w+3], model[w+2], model[w+1], model[w]};
  endfunction

  // Drop the core request the cycle after its ack
  task automatic release_core();
    if (core_acked) begin
      core_req   = '0;
      core_acked = 1'b0;
      core_wait  = 0;
    end
  endtask

  // Core port checks at the sample point
  task automatic sample_core();
    check_value("core_rvalid", 32'(core_rd_pend), 32'(core_resp.rvalid));
    if (core_rd_pend) begin
      check_value("core_rdata", model_word(core_rd_addr), core_resp.rdata);
      core_rd_pend = 1'b0;
    end
    if (core_req.req) begin
      core_wait++;
      if (core_resp.ack) begin
        core_acked = 1'b1;
        if (core_req.we) begin
          for (int b = 0; b < 4; b++) begin
            model[int'(core_req.addr) + b] = core_req.wdata[8*b +: 8];
          end
        end else begin
          // Read data is due one cycle after ack
          core_rd_pend = 1'b1;
          core_rd_addr = addr_t'(core_req.addr);
        end
      end else if (core_wait > 16) begin
        $display("Core request at %h was not acknowledged within 16 cycles", core_req.addr);
        errors++;
        core_acked = 1'b1;
      end
    end
  endtask

  initial begin
    int          idx, drow, dcyc, total, exp_cyc;
    int          nbytes, base;
    logic        is_data;
    logic [31:0] wdata, r;

    lfsr_q       = 32'd99;
    errors       = 0;
    limit        = 0;
    n_rows       = 0;
    rst_ni       = 1'b0;
    ahb_req      = '0;
    core_req     = '0;
    core_acked   = 1'b0;
    core_wait    = 0;
    core_rd_pend = 1'b0;
    core_rd_addr = '0;
    wdata        = '0;

    // Single word access
    add_row("b1_wr_word", AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd2, 1'b1, 32'h000, 0);
    add_row("b1_rd_word", AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd2, 1'b0, 32'h000, 0);
    // Byte and halfword lanes
    add_row("b2_wr_word", AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd2, 1'b1, 32'h010, 0);
    add_row("b2_wr_b0",   AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd0, 1'b1, 32'h010, 0);
    add_row("b2_wr_b1",   AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd0, 1'b1, 32'h011, 0);
    add_row("b2_wr_b2",   AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd0, 1'b1, 32'h012, 0);
    add_row("b2_wr_b3",   AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd0, 1'b1, 32'h013, 0);
    add_row("b2_rd_bytes", AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd2, 1'b0, 32'h010, 0);
    add_row("b2_wr_h0",   AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd1, 1'b1, 32'h010, 0);
    add_row("b2_wr_h2",   AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd1, 1'b1, 32'h012, 0);
    add_row("b2_rd_halfs", AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd2, 1'b0, 32'h010, 0);
    // INCR4 write then read
    add_row("b3_wr_beat0", AHB_TRANS_NONSEQ, AHB_BURST_INCR4, 3'd2, 1'b1, 32'h020, 0);
    add_row("b3_wr_beat1", AHB_TRANS_SEQ,    AHB_BURST_INCR4, 3'd2, 1'b1, 32'h024, 0);
    add_row("b3_wr_beat2", AHB_TRANS_SEQ,    AHB_BURST_INCR4, 3'd2, 1'b1, 32'h028, 0);
    add_row("b3_wr_beat3", AHB_TRANS_SEQ,    AHB_BURST_INCR4, 3'd2, 1'b1, 32'h02C, 0);
    add_row("b3_rd_beat0", AHB_TRANS_NONSEQ, AHB_BURST_INCR4, 3'd2, 1'b0, 32'h020, 0);
    add_row("b3_rd_beat1", AHB_TRANS_SEQ,    AHB_BURST_INCR4, 3'd2, 1'b0, 32'h024, 0);
    add_row("b3_rd_beat2", AHB_TRANS_SEQ,    AHB_BURST_INCR4, 3'd2, 1'b0, 32'h028, 0);
    add_row("b3_rd_beat3", AHB_TRANS_SEQ,    AHB_BURST_INCR4, 3'd2, 1'b0, 32'h02C, 0);
    // INCR with BUSY ended first by IDLE and then by NONSEQ
    add_row("b4_wr_first", AHB_TRANS_NONSEQ, AHB_BURST_INCR, 3'd2, 1'b1, 32'h040, 0);
    add_row("b4_wr_busy",  AHB_TRANS_BUSY,   AHB_BURST_INCR, 3'd2, 1'b1, 32'h044, 0);
    add_row("b4_wr_seq",   AHB_TRANS_SEQ,    AHB_BURST_INCR, 3'd2, 1'b1, 32'h044, 0);
    add_row("b4_idle",     AHB_TRANS_IDLE,   AHB_BURST_SINGLE, 3'd2, 1'b0, 32'h000, 0);
    add_row("b4_rd_first", AHB_TRANS_NONSEQ, AHB_BURST_INCR, 3'd2, 1'b0, 32'h040, 0);
    add_row("b4_rd_busy",  AHB_TRANS_BUSY,   AHB_BURST_INCR, 3'd2, 1'b0, 32'h044, 0);
    add_row("b4_rd_seq",   AHB_TRANS_SEQ,    AHB_BURST_INCR, 3'd2, 1'b0, 32'h044, 0);
    add_row("b4_rd_new",   AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd2, 1'b0, 32'h040, 0);
    // Core contention
    add_row("b5_rd_beat0", AHB_TRANS_NONSEQ, AHB_BURST_INCR4, 3'd2, 1'b0, 32'h020, 2);
    add_row("b5_rd_beat1", AHB_TRANS_SEQ,    AHB_BURST_INCR4, 3'd2, 1'b0, 32'h024, 2);
    add_row("b5_rd_beat2", AHB_TRANS_SEQ,    AHB_BURST_INCR4, 3'd2, 1'b0, 32'h028, 2);
    add_row("b5_rd_beat3", AHB_TRANS_SEQ,    AHB_BURST_INCR4, 3'd2, 1'b0, 32'h02C, 2);
    add_row("b5_wr_word",  AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd2, 1'b1, 32'h000, 3);
    add_row("b5_rd_word",  AHB_TRANS_NONSEQ, AHB_BURST_SINGLE, 3'd2, 1'b0, 32'h000, 3);

    total = 0;
    for (int i = 0; i < n_rows; i++) begin
      total += (row_load[i] != 0) ? 8 : 2;
    end
    limit = 4 * total + RESET_CYC;

    repeat (RESET_CYC) @(negedge clk_i);
    rst_ni = 1'b1;
    #(PERIOD/2 - 10);
    check_value("reset_hready", 32'd1, 32'(ahb_resp.hready));
    check_value("reset_hresp", 32'd0, 32'(ahb_resp.hresp));

    // ------------------------------------------------------------
    // Pipeline loop with the address of row idx over the data phase of row drow
    // ------------------------------------------------------------
    idx  = 0;
    drow = -1;
    dcyc = 0;
    while (idx < n_rows || drow >= 0) begin
      @(negedge clk_i);
      release_core();
      if (!core_req.req && idx < n_rows && row_load[idx] != 0) begin
        r = take_bits(2);
        if (int'(r) < row_load[idx]) begin
          core_req.req   = 1'b1;
          r              = take_bits(1);
          core_req.we    = r[0];
          core_req.be    = 4'hF;
          r              = take_bits(9);
          core_req.addr  = {1'b1, r[8:0], 2'b00};
          core_req.wdata = take_bits(32);
        end
      end
      if (idx < n_rows) begin
        ahb_req.htrans = row_trans[idx];
        ahb_req.hburst = row_burst[idx];
        ahb_req.hsize  = row_size[idx];
        ahb_req.hwrite = row_write[idx];
        ahb_req.haddr  = row_addr[idx];
      end else begin
        ahb_req.htrans = AHB_TRANS_IDLE;
        ahb_req.hwrite = 1'b0;
      end
      ahb_req.hwdata = wdata;

      // Sample where every output is settled
      #(PERIOD/2 - 10);
      dcyc++;
      check_value("hresp", 32'd0, 32'(ahb_resp.hresp));
      sample_core();
      if (!ahb_resp.hready) begin
        continue;
      end

      if (drow >= 0) begin
        is_data = (row_trans[drow] == AHB_TRANS_NONSEQ) || (row_trans[drow] == AHB_TRANS_SEQ);
        if (is_data && row_write[drow]) begin
          nbytes = 1 << row_size[drow];
          base   = int'(row_addr[drow][11:0]) & ~(nbytes - 1);
          for (int b = 0; b < nbytes; b++) begin
            model[base + b] = wdata[8*((base + b) % 4) +: 8];
          end
        end else if (is_data) begin
          check_value(row_name[drow], model_word(row_addr[drow]), ahb_resp.hrdata);
        end
        if (row_load[drow] == 0) begin
          // A read behind a write data phase goes out one cycle later
          exp_cyc = 1;
          if (is_data && !row_write[drow] && drow > 0 && row_write[drow-1] &&
              (row_trans[drow-1] == AHB_TRANS_NONSEQ || row_trans[drow-1] == AHB_TRANS_SEQ)) begin
            exp_cyc = 2;
          end
          check_value({row_name[drow], "_cycles"}, 32'(exp_cyc), 32'(dcyc));
        end
        $display("%-12s done in %0d cycles, errors so far %0d", row_name[drow], dcyc, errors);
      end

      if (idx < n_rows) begin
        drow  = idx;
        wdata = take_bits(32);
        idx++;
      end else begin
        drow = -1;
      end
      dcyc = 0;
    end

    // Let the last core access finish
    while (core_req.req || core_rd_pend) begin
      @(negedge clk_i);
      release_core();
      #(PERIOD/2 - 10);
      sample_core();
    end

    $display("Ran %0d tests in %0d cycles with %0d errors", n_rows, cycles, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- ahb_spm_top.sv
/*
 * AHB-Lite scratchpad bridge with a shared core port
 * Core port follows the same req and ack rules as the AHB side
 * hresp is always OKAY
 */
`timescale 1ns/1ps

module ahb_spm_top
  import ahb_pkg::*;
  import spm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  ahb_req_t  ahb_req_i,
  input  spm_req_t  core_req_i,
  output ahb_resp_t ahb_resp_o,
  output spm_resp_t core_resp_o
);

  // Adapter to arbiter
  spm_req_t  ahb_spm_req;
  spm_resp_t ahb_spm_resp;
  logic      ahb_burst;

  // Arbiter to RAM
  spm_req_t  mem_req;
  data_t     mem_rdata;

  ahb_slave_adapter u_adapter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ahb_req_i   (ahb_req_i),
    .spm_resp_i  (ahb_spm_resp),
    .ahb_resp_o  (ahb_resp_o),
    .spm_req_o   (ahb_spm_req),
    .ahb_burst_o (ahb_burst)
  );

  spm_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .core_req_i  (core_req_i),
    .ahb_req_i   (ahb_spm_req),
    .ahb_burst_i (ahb_burst),
    .mem_rdata_i (mem_rdata),
    .core_resp_o (core_resp_o),
    .ahb_resp_o  (ahb_spm_resp),
    .mem_req_o   (mem_req)
  );

  spm_ram u_ram (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mem_req_i (mem_req),
    .rdata_o   (mem_rdata)
  );

endmodule

//--- ahb_slave_adapter.sv
/*
 * AHB-Lite slave that turns each data transfer into one scratchpad request
 * Reads go out in the address phase when the port is free, writes in the data phase
 * A read right after a write goes out in its data phase, one extra cycle
 * hresp is always OKAY, WRAP bursts are treated as INCR
 */
`timescale 1ns/1ps
`include "spm_macros.svh"

module ahb_slave_adapter
  import ahb_pkg::*;
  import spm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  ahb_req_t  ahb_req_i,
  input  spm_resp_t spm_resp_i,
  output ahb_resp_t ahb_resp_o,
  output spm_req_t  spm_req_o,
  output logic      ahb_burst_o
);

  // Data phase being served
  typedef enum logic [2:0] {
    S_IDLE,
    S_BUSY,
    S_NONSEQ_READ,
    S_NONSEQ_WRITE,
    S_SEQ_READ,
    S_SEQ_WRITE
  } state_e;

  state_e     state_q, state_d;
  state_e     state_nxt;
  ahb_burst_e burst_q;
  addr_t      addr_q;
  ahb_size_t  size_q;
  logic       hready;
  logic       rd_phase, wr_phase;
  logic       port_free;
  spm_req_t   spm_req;

  // Lane mask from transfer size and low address bits
  function automatic be_t calc_be(input logic [1:0] offset, input ahb_size_t size);
    be_t be;
    case (size)
      3'd0:    be = be_t'(4'b0001 << offset);
      3'd1:    be = be_t'(4'b0011 << {offset[1], 1'b0});
      default: be = '1;
    endcase
    return be;
  endfunction

  // State entered if the current address phase is sampled
  function automatic state_e next_state(input state_e cur, input ahb_req_t req,
                                        input ahb_burst_e burst);
    state_e nxt;
    logic   leave_busy;
    leave_busy = (burst == AHB_BURST_INCR);
    case (req.htrans)
      AHB_TRANS_NONSEQ: nxt = req.hwrite ? S_NONSEQ_WRITE : S_NONSEQ_READ;
      AHB_TRANS_SEQ:    nxt = req.hwrite ? S_SEQ_WRITE : S_SEQ_READ;
      AHB_TRANS_BUSY:   nxt = S_BUSY;
      default:          nxt = S_IDLE;
    endcase
    // A fixed-length burst only resumes from BUSY with SEQ
    if (cur == S_BUSY && !leave_busy &&
        (req.htrans == AHB_TRANS_IDLE || req.htrans == AHB_TRANS_NONSEQ)) begin
      nxt = S_BUSY;
    end
    return nxt;
  endfunction

  // ------------------------------------------------------------
  // Data phase status
  // ------------------------------------------------------------

  assign rd_phase = (state_q == S_NONSEQ_READ) || (state_q == S_SEQ_READ);
  assign wr_phase = (state_q == S_NONSEQ_WRITE) || (state_q == S_SEQ_WRITE);

  // Reads end on rvalid, writes end on ack
  always_comb begin
    hready = 1'b1;
    if (rd_phase) begin
      hready = spm_resp_i.rvalid;
    end else if (wr_phase) begin
      hready = spm_resp_i.ack;
    end
  end

  // Port is free when no data-phase request is pending
  // Built without ack so that the request never depends on its own grant
  assign port_free = (state_q == S_IDLE) || (state_q == S_BUSY) ||
                     (rd_phase && spm_resp_i.rvalid);

  // ------------------------------------------------------------
  // Transfer FSM
  // ------------------------------------------------------------

  assign state_nxt = next_state(state_q, ahb_req_i, burst_q);

  // Address phase is sampled only while hready is high
  assign state_d = hready ? state_nxt : state_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
      burst_q <= AHB_BURST_SINGLE;
    end else begin
      state_q <= state_d;
      // Burst type is fixed by the NONSEQ that opens it
      if (hready && (state_d == S_NONSEQ_READ || state_d == S_NONSEQ_WRITE)) begin
        burst_q <= ahb_req_i.hburst;
      end
    end
  end

  // Address and size of the accepted transfer
  always_ff @(posedge clk_i) begin
    if (hready && state_d != S_IDLE && state_d != S_BUSY) begin
      addr_q <= ahb_req_i.haddr;
      size_q <= ahb_req_i.hsize;
    end
  end

  // ------------------------------------------------------------
  // Scratchpad request
  // ------------------------------------------------------------

  always_comb begin
    spm_req = '0;
    if (wr_phase) begin
      // Write beat with hwdata of this data phase
      spm_req.req   = 1'b1;
      spm_req.we    = 1'b1;
      spm_req.be    = calc_be(addr_q[1:0], size_q);
      spm_req.addr  = addr_q[`SPM_ADDR_W-1:0];
      spm_req.wdata = ahb_req_i.hwdata;
    end else if (rd_phase && !spm_resp_i.rvalid) begin
      // Read not granted yet, retry from the registered address
      spm_req.req  = 1'b1;
      spm_req.be   = calc_be(addr_q[1:0], size_q);
      spm_req.addr = addr_q[`SPM_ADDR_W-1:0];
    end else if (port_free &&
                 (state_nxt == S_NONSEQ_READ || state_nxt == S_SEQ_READ)) begin
      // Early read straight from the address phase
      spm_req.req  = 1'b1;
      spm_req.be   = calc_be(ahb_req_i.haddr[1:0], ahb_req_i.hsize);
      spm_req.addr = ahb_req_i.haddr[`SPM_ADDR_W-1:0];
    end
  end

  assign spm_req_o = spm_req;

  // Arbiter lock request while the master continues a burst
  assign ahb_burst_o = (ahb_req_i.htrans == AHB_TRANS_SEQ);

  // ------------------------------------------------------------
  // AHB response
  // ------------------------------------------------------------

  always_comb begin
    ahb_resp_o.hready = hready;
    ahb_resp_o.hresp  = 1'b0;
    ahb_resp_o.hrdata = '0;
    if (rd_phase && spm_resp_i.rvalid) begin
      ahb_resp_o.hrdata = spm_resp_i.rdata;
    end
  end

endmodule

//--- spm_arbiter.sv
/*
 * Two-port arbiter in front of the scratchpad RAM
 * Core wins, unless an AHB burst holds the port it was last granted
 * Requesters keep one read in flight, rvalid goes back to the owner at ack
 */
`timescale 1ns/1ps

module spm_arbiter
  import ahb_pkg::*;
  import spm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  spm_req_t  core_req_i,
  input  spm_req_t  ahb_req_i,
  input  logic      ahb_burst_i,
  input  data_t     mem_rdata_i,
  output spm_resp_t core_resp_o,
  output spm_resp_t ahb_resp_o,
  output spm_req_t  mem_req_o
);

  spm_owner_e last_owner_q;
  spm_owner_e rd_owner_q;
  logic       rd_pend_q;
  logic       grant_core, grant_ahb;
  logic       burst_lock;

  // ------------------------------------------------------------
  // Grant
  // ------------------------------------------------------------

  // Burst lock only keeps a grant the AHB side already holds
  assign burst_lock = ahb_burst_i && (last_owner_q == OWNER_AHB);

  assign grant_ahb  = ahb_req_i.req && (!core_req_i.req || burst_lock);
  assign grant_core = core_req_i.req && !grant_ahb;

  // Forward the winner, req marks an access this cycle
  always_comb begin
    mem_req_o     = grant_ahb ? ahb_req_i : core_req_i;
    mem_req_o.req = grant_ahb || grant_core;
  end

  // ------------------------------------------------------------
  // Owner tracking
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_owner_q <= OWNER_CORE;
      rd_owner_q   <= OWNER_CORE;
      rd_pend_q    <= 1'b0;
    end else begin
      if (grant_ahb) begin
        last_owner_q <= OWNER_AHB;
      end else if (grant_core) begin
        last_owner_q <= OWNER_CORE;
      end
      // RAM returns data the cycle after a granted read
      rd_pend_q  <= mem_req_o.req && !mem_req_o.we;
      rd_owner_q <= grant_ahb ? OWNER_AHB : OWNER_CORE;
    end
  end

  // ------------------------------------------------------------
  // Responses
  // ------------------------------------------------------------

  always_comb begin
    core_resp_o.ack    = grant_core;
    core_resp_o.rvalid = rd_pend_q && (rd_owner_q == OWNER_CORE);
    core_resp_o.rdata  = core_resp_o.rvalid ? mem_rdata_i : '0;

    ahb_resp_o.ack     = grant_ahb;
    ahb_resp_o.rvalid  = rd_pend_q && (rd_owner_q == OWNER_AHB);
    ahb_resp_o.rdata   = ahb_resp_o.rvalid ? mem_rdata_i : '0;
  end

endmodule

//--- spm_ram.sv
/*
 * Single-port word RAM for the scratchpad
 * Writes land at the access edge under byte enables
 * Reads return one cycle after the access, the output holds until the next read
 * Address bits above the word range are ignored
 */
`timescale 1ns/1ps
`include "spm_macros.svh"

module spm_ram
  import ahb_pkg::*;
  import spm_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  spm_req_t mem_req_i,
  output data_t    rdata_o
);

  localparam int WORD_AW = $clog2(`SPM_DEPTH);
  localparam int LANES   = $bits(be_t);

  data_t              mem [`SPM_DEPTH];
  data_t              rdata_q;
  logic [WORD_AW-1:0] word_idx;

  // Byte address to word index
  assign word_idx = mem_req_i.addr[WORD_AW+1:2];

  // ------------------------------------------------------------
  // Write port
  // ------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (mem_req_i.req && mem_req_i.we) begin
      for (int b = 0; b < LANES; b++) begin
        // Only enabled lanes change
        if (mem_req_i.be[b]) begin
          mem[word_idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Read port
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (mem_req_i.req && !mem_req_i.we) begin
      rdata_q <= mem[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- spm_pkg.sv
/*
 * Scratchpad port types used by the adapter, the arbiter and the RAM
 * A request holds until ack, read data follows ack by one cycle
 */
`include "spm_macros.svh"

package spm_pkg;

  // One enable bit per byte lane of a data word
  typedef logic [`AHB_DATA_W/8-1:0] be_t;

  // Byte address inside the scratchpad
  typedef logic [`SPM_ADDR_W-1:0] spm_addr_t;

  // Single-beat request
  typedef struct packed {
    logic           req;
    logic           we;
    be_t            be;
    spm_addr_t      addr;
    ahb_pkg::data_t wdata;
  } spm_req_t;

  // Grant strobe and read return
  typedef struct packed {
    logic           ack;
    logic           rvalid;
    ahb_pkg::data_t rdata;
  } spm_resp_t;

  // Side that holds or last held the scratchpad
  typedef enum logic {
    OWNER_CORE = 1'b0,
    OWNER_AHB  = 1'b1
  } spm_owner_e;

endpackage

//--- ahb_pkg.sv
/*
 * AHB-Lite bus types shared by the master side and the adapter
 * Only OKAY responses exist, hprot and hmastlock are not carried
 */
`include "spm_macros.svh"

package ahb_pkg;

  // Bus vectors
  typedef logic [`AHB_ADDR_W-1:0] addr_t;
  typedef logic [`AHB_DATA_W-1:0] data_t;
  typedef logic [2:0]             ahb_size_t;

  // htrans encoding
  typedef enum logic [1:0] {
    AHB_TRANS_IDLE   = 2'b00,
    AHB_TRANS_BUSY   = 2'b01,
    AHB_TRANS_NONSEQ = 2'b10,
    AHB_TRANS_SEQ    = 2'b11
  } ahb_trans_e;

  // hburst encoding, WRAP types are addressed like INCR here
  typedef enum logic [2:0] {
    AHB_BURST_SINGLE = 3'b000,
    AHB_BURST_INCR   = 3'b001,
    AHB_BURST_WRAP4  = 3'b010,
    AHB_BURST_INCR4  = 3'b011,
    AHB_BURST_WRAP8  = 3'b100,
    AHB_BURST_INCR8  = 3'b101,
    AHB_BURST_WRAP16 = 3'b110,
    AHB_BURST_INCR16 = 3'b111
  } ahb_burst_e;

  // Master to slave, 73 bits
  typedef struct packed {
    ahb_trans_e htrans;
    ahb_burst_e hburst;
    ahb_size_t  hsize;
    logic       hwrite;
    addr_t      haddr;
    data_t      hwdata;
  } ahb_req_t;

  // Slave to master, 34 bits
  typedef struct packed {
    data_t hrdata;
    logic  hready;
    logic  hresp;
  } ahb_resp_t;

endpackage

//--- spm_macros.svh
/*
 * Global widths for the AHB to scratchpad bridge
 * SPM_ADDR_W is a byte address and must cover SPM_DEPTH words of 4 bytes
 * The AHB data width is fixed at 32 bits
 */
`ifndef SPM_MACROS_SVH
`define SPM_MACROS_SVH

// AHB-Lite bus widths
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// Scratchpad byte address width, 4 KiB
`define SPM_ADDR_W 12

// Number of 32-bit words in the scratchpad
`define SPM_DEPTH 1024

`endif
